/* common/rvExec_params.svh */
/*
 * Build constants for the RV32 execute slice.
 * Data width, operation queue depth and the shifter's large step.
 */
`ifndef RVEXEC_PARAMS_SVH
`define RVEXEC_PARAMS_SVH

// Data path width
`define RVX_XLEN 32

// Entries in the operation queue
// Busy rises one entry before full
`define RVX_QUEUE_DEPTH 4

// Large step of the two-level shifter
// Used while at least this much shift remains
`define RVX_SHIFT_STEP 4

`endif

/* common/rvExecPkg.sv */
/*
 * Shared types for the RV32 execute slice.
 * Major opcodes, ALU operations and the ALU sequencer states.
 */
`default_nettype none

package rvExecPkg;

   // Major opcode, instr[6:2]
   typedef enum logic [4:0] {
      OP_IMM    = 5'b00100,   // rd <- rs1 op Iimm
      OP_REG    = 5'b01100,   // rd <- rs1 op rs2
      OP_LUI    = 5'b01101,   // rd <- Uimm
      OP_BRANCH = 5'b11000,   // Conditional branch, predicate only
      OP_OTHER  = 5'b11111    // Anything not handled here
   } majorOp_t;

   // Operation performed by the ALU
   typedef enum logic [4:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      // Branch compares
      ALU_BEQ,
      ALU_BNE,
      ALU_BLT,
      ALU_BGE,
      ALU_BLTU,
      ALU_BGEU,
      ALU_PASS                // Forward in2, used by LUI
   } aluOp_t;

   // ALU sequencer
   typedef enum logic [0:0] {
      ST_IDLE,                // Accepts a new operation
      ST_SHIFT                // Iterating a shift
   } aluState_t;

endpackage

`default_nettype wire

/* common/aluOpIf.sv */
/*
 * Decoded operation bundle.
 * Carries one operation and its two operands with a valid strobe.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_params.svh"

interface aluOpIf
   import rvExecPkg::*;
();

   logic                 valid;   // One-cycle strobe
   aluOp_t               op;      // Operation to perform
   logic [`RVX_XLEN-1:0] in1;     // First operand, rs1
   logic [`RVX_XLEN-1:0] in2;     // Second operand, rs2 or immediate

   // Producer side
   modport src (output valid, output op, output in1, output in2);

   // Consumer side
   modport dst (input valid, input op, input in1, input in2);

endinterface

`default_nettype wire

/* decoder/instrDecoder.sv */
/*
 * Instruction decoder.
 * Classifies the word, selects the second operand and registers
 * the decoded ALU operation onto decOp.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_params.svh"

module instrDecoder
   import rvExecPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 instrValid,
   input  logic [`RVX_XLEN-1:0] instr,
   input  logic [`RVX_XLEN-1:0] rs1Data,
   input  logic [`RVX_XLEN-1:0] rs2Data,
   aluOpIf.src                  decOp
);

   majorOp_t             major;
   aluOp_t               decodedOp;
   logic [2:0]           funct3;
   logic [`RVX_XLEN-1:0] iImm;
   logic [`RVX_XLEN-1:0] uImm;
   logic [`RVX_XLEN-1:0] operand2;

   assign funct3 = instr[14:12];
   assign iImm   = {{(`RVX_XLEN-12){instr[31]}}, instr[31:20]};  // Sign-extended
   assign uImm   = {instr[31:12], 12'b0};                        // Low 12 bits zero

   // Major opcode from instr[6:2]
   always_comb begin
      case (instr[6:2])
         OP_IMM:    major = OP_IMM;
         OP_REG:    major = OP_REG;
         OP_LUI:    major = OP_LUI;
         OP_BRANCH: major = OP_BRANCH;
         default:   major = OP_OTHER;
      endcase
   end

   // Operation select
   always_comb begin
      decodedOp = ALU_ADD;
      case (major)
         OP_REG, OP_IMM: begin
            case (funct3)
               // Bit 5 separates ADD/SUB from ADDI, whose immediate overlaps bit 30
               3'b000:  decodedOp = (instr[30] && instr[5]) ? ALU_SUB : ALU_ADD;
               3'b001:  decodedOp = ALU_SLL;
               3'b010:  decodedOp = ALU_SLT;
               3'b011:  decodedOp = ALU_SLTU;
               3'b100:  decodedOp = ALU_XOR;
               3'b101:  decodedOp = instr[30] ? ALU_SRA : ALU_SRL;
               3'b110:  decodedOp = ALU_OR;
               default: decodedOp = ALU_AND;
            endcase
         end
         OP_BRANCH: begin
            case (funct3)
               3'b001:  decodedOp = ALU_BNE;
               3'b100:  decodedOp = ALU_BLT;
               3'b101:  decodedOp = ALU_BGE;
               3'b110:  decodedOp = ALU_BLTU;
               3'b111:  decodedOp = ALU_BGEU;
               default: decodedOp = ALU_BEQ;   // Reserved codes fall back to BEQ
            endcase
         end
         OP_LUI:  decodedOp = ALU_PASS;
         default: decodedOp = ALU_ADD;
      endcase
   end

   // Register ops and branches compare rs2, immediate ops use Iimm
   assign operand2 = (major == OP_LUI) ? uImm :
                     (major == OP_IMM) ? iImm : rs2Data;

   always_ff @(posedge clk) begin
      if (!reset) begin
         decOp.valid <= 1'b0;
      end else begin
         decOp.valid <= instrValid && (major != OP_OTHER);  // Discarded words never push
      end
   end

   always_ff @(posedge clk) begin
      if (instrValid) begin
         decOp.op  <= decodedOp;
         decOp.in1 <= rs1Data;
         decOp.in2 <= operand2;
      end
   end

   // An unsupported major opcode must not reach the queue
   noPushOnOther: assert property (@(posedge clk) disable iff (!reset)
      (instrValid && !(instr[6:2] inside {OP_IMM, OP_REG, OP_LUI, OP_BRANCH}))
      |=> !decOp.valid)
      else $error("decoder pushed an unsupported instruction");

endmodule

`default_nettype wire

/* rtl/opQueue.sv */
/*
 * Operation queue between decoder and ALU.
 * Circular buffer, issues the oldest entry when the ALU is idle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_params.svh"

module opQueue
   import rvExecPkg::*;
(
   input  logic clk,
   input  logic reset,
   aluOpIf.dst  decOp,
   aluOpIf.src  issueOp,
   input  logic aluIdle,
   output logic busy
);

   localparam int ptrWidth = $clog2(`RVX_QUEUE_DEPTH);
   localparam int cntWidth = $clog2(`RVX_QUEUE_DEPTH + 1);
   localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(`RVX_QUEUE_DEPTH - 1);
   localparam logic [cntWidth-1:0] fullCount = cntWidth'(`RVX_QUEUE_DEPTH);

   aluOp_t               opMem  [`RVX_QUEUE_DEPTH];
   logic [`RVX_XLEN-1:0] in1Mem [`RVX_QUEUE_DEPTH];
   logic [`RVX_XLEN-1:0] in2Mem [`RVX_QUEUE_DEPTH];

   logic [ptrWidth-1:0] wrPtr;
   logic [ptrWidth-1:0] rdPtr;
   logic [cntWidth-1:0] count;     // Occupancy
   logic                push;
   logic                pop;

   assign push = decOp.valid;
   assign pop  = (count != '0) && aluIdle;   // Oldest entry leaves when ALU is free

   // Head of queue straight from storage
   assign issueOp.valid = pop;
   assign issueOp.op    = opMem[rdPtr];
   assign issueOp.in1   = in1Mem[rdPtr];
   assign issueOp.in2   = in2Mem[rdPtr];

   // One slot kept for the operation still in the decoder
   assign busy = count >= cntWidth'(`RVX_QUEUE_DEPTH - 1);

   always_ff @(posedge clk) begin
      if (push) begin
         opMem[wrPtr]  <= decOp.op;
         in1Mem[wrPtr] <= decOp.in1;
         in2Mem[wrPtr] <= decOp.in2;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push)
            wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;   // Wrap
         if (pop)
            rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // Busy must hold off the source before the buffer fills
   noPushWhenFull: assert property (@(posedge clk) disable iff (!reset)
      push |-> (count != fullCount))
      else $error("push into a full operation queue");

   // Pointers and count must agree whenever an entry leaves
   noPopWhenEmpty: assert property (@(posedge clk) disable iff (!reset)
      pop |-> ((rdPtr != wrPtr) || (count == fullCount)))
      else $error("pop from an empty operation queue");

endmodule

`default_nettype wire

/* alu/aluCore.sv */
/*
 * ALU with two-level iterative shifter and branch predicate.
 * Single-cycle arithmetic and logic, shifts step by a large
 * increment and then by one.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_params.svh"

module aluCore
   import rvExecPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   aluOpIf.dst                  issueOp,
   output logic                 aluIdle,
   output logic                 resultValid,
   output logic                 isBranch,
   output logic                 taken,
   output logic [`RVX_XLEN-1:0] result
);

   localparam int shamtWidth = $clog2(`RVX_XLEN);
   localparam logic [shamtWidth-1:0] bigStep = shamtWidth'(`RVX_SHIFT_STEP);

   aluState_t             state;
   aluOp_t                curOp;        // Held for the shift direction
   logic [shamtWidth-1:0] shamt;        // Remaining shift amount
   logic [`RVX_XLEN-1:0]  aluReg;       // Result and shift register
   logic [`RVX_XLEN:0]    aluMinus;     // 33-bit difference
   logic                  lt;
   logic                  ltu;
   logic                  eq;
   logic                  predicate;
   logic                  isShift;
   logic                  isBranchOp;
   logic                  accept;
   logic                  fill;
   logic [`RVX_XLEN-1:0]  loadValue;
   logic [`RVX_XLEN-1:0]  bigShifted;
   logic [`RVX_XLEN-1:0]  oneShifted;

   assign aluIdle = (state == ST_IDLE);
   assign accept  = aluIdle && issueOp.valid;
   assign result  = aluReg;

   // One subtract serves SUB and every compare
   assign aluMinus = {1'b0, issueOp.in1} - {1'b0, issueOp.in2};
   assign ltu      = aluMinus[`RVX_XLEN];
   assign lt       = (issueOp.in1[`RVX_XLEN-1] ^ issueOp.in2[`RVX_XLEN-1]) ?
                     issueOp.in1[`RVX_XLEN-1] : aluMinus[`RVX_XLEN];
   assign eq       = (aluMinus[`RVX_XLEN-1:0] == '0);

   assign isShift    = (issueOp.op == ALU_SLL) || (issueOp.op == ALU_SRL) ||
                       (issueOp.op == ALU_SRA);
   assign isBranchOp = (issueOp.op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
                                           ALU_BLTU, ALU_BGEU});

   always_comb begin
      predicate = 1'b0;   // Zero for anything but a branch
      case (issueOp.op)
         ALU_BEQ:  predicate = eq;
         ALU_BNE:  predicate = !eq;
         ALU_BLT:  predicate = lt;
         ALU_BGE:  predicate = !lt;
         ALU_BLTU: predicate = ltu;
         ALU_BGEU: predicate = !ltu;
         default:  predicate = 1'b0;
      endcase
   end

   // Value captured in the load cycle
   always_comb begin
      case (issueOp.op)
         ALU_ADD:                   loadValue = issueOp.in1 + issueOp.in2;
         ALU_SUB:                   loadValue = aluMinus[`RVX_XLEN-1:0];
         ALU_SLT:                   loadValue = {{(`RVX_XLEN-1){1'b0}}, lt};
         ALU_SLTU:                  loadValue = {{(`RVX_XLEN-1){1'b0}}, ltu};
         ALU_XOR:                   loadValue = issueOp.in1 ^ issueOp.in2;
         ALU_OR:                    loadValue = issueOp.in1 | issueOp.in2;
         ALU_AND:                   loadValue = issueOp.in1 & issueOp.in2;
         ALU_PASS:                  loadValue = issueOp.in2;   // LUI immediate
         ALU_SLL, ALU_SRL, ALU_SRA: loadValue = issueOp.in1;   // Shift source
         default:                   loadValue = '0;            // Branches return zero
      endcase
   end

   // Sign fill only for SRA
   assign fill = (curOp == ALU_SRA) && aluReg[`RVX_XLEN-1];

   assign bigShifted = (curOp == ALU_SLL) ? aluReg << `RVX_SHIFT_STEP :
                       {{`RVX_SHIFT_STEP{fill}}, aluReg[`RVX_XLEN-1:`RVX_SHIFT_STEP]};
   assign oneShifted = (curOp == ALU_SLL) ? aluReg << 1 :
                       {fill, aluReg[`RVX_XLEN-1:1]};

   always_ff @(posedge clk) begin
      if (!reset) begin
         state       <= ST_IDLE;
         shamt       <= '0;
         resultValid <= 1'b0;
      end else begin
         resultValid <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  if (isShift) begin
                     state <= ST_SHIFT;
                     shamt <= issueOp.in2[shamtWidth-1:0];   // Low five bits
                  end else begin
                     resultValid <= 1'b1;   // Done in the load cycle
                  end
               end
            end
            default: begin
               if (shamt >= bigStep)
                  shamt <= shamt - bigStep;
               else if (shamt != '0)
                  shamt <= shamt - 1'b1;
               else begin
                  resultValid <= 1'b1;      // Remaining amount reached zero
                  state       <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         curOp    <= issueOp.op;
         aluReg   <= loadValue;
         isBranch <= isBranchOp;
         taken    <= predicate;
      end else if (state == ST_SHIFT) begin
         if (shamt >= bigStep)
            aluReg <= bigShifted;   // Large step first
         else if (shamt != '0)
            aluReg <= oneShifted;
      end
   end

   // Queue must wait for the shifter
   noPopWhileBusy: assert property (@(posedge clk) disable iff (!reset)
      issueOp.valid |-> (state == ST_IDLE))
      else $error("operation issued while the ALU was shifting");

   resultAfterShift: assert property (@(posedge clk) disable iff (!reset)
      resultValid |-> (shamt == '0))
      else $error("result strobe with shift still pending");

endmodule

`default_nettype wire

/* rtl/rvExecTop.sv */
/*
 * RV32 execute slice top level.
 * Decoder, operation queue and ALU in a chain.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_params.svh"

module rvExecTop (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 instrValid,   // Strobe only while busy is low
   input  logic [`RVX_XLEN-1:0] instr,
   input  logic [`RVX_XLEN-1:0] rs1Data,
   input  logic [`RVX_XLEN-1:0] rs2Data,
   output logic                 busy,
   output logic                 resultValid,
   output logic [`RVX_XLEN-1:0] result,
   output logic                 isBranch,
   output logic                 taken
);

   logic aluIdle;   // ALU can take an operation

   aluOpIf decOp ();     // Decoder to queue
   aluOpIf issueOp ();   // Queue to ALU

   instrDecoder u_instrDecoder (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .decOp      (decOp)
   );

   opQueue u_opQueue (
      .clk     (clk),
      .reset   (reset),
      .decOp   (decOp),
      .issueOp (issueOp),
      .aluIdle (aluIdle),
      .busy    (busy)
   );

   aluCore u_aluCore (
      .clk         (clk),
      .reset       (reset),
      .issueOp     (issueOp),
      .aluIdle     (aluIdle),
      .resultValid (resultValid),
      .isBranch    (isBranch),
      .taken       (taken),
      .result      (result)
   );

endmodule

`default_nettype wire

/* verification/tbClock.sv */
/*
 * Testbench clock and reset.
 * 100 ns clock, active-low reset held for 16 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // Half period
   end

   initial begin
      reset = 1'b0;              // Asserted from time zero
      repeat (16) @(posedge clk);
      reset <= 1'b1;
   end

endmodule

`default_nettype wire

/* verification/rvExecTb.sv */
/*
 * Testbench for the RV32 execute slice.
 * Random instruction words from an LCG, checked against an RV32I model
 * in issue order, with a cycle limit on the whole run.
 */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_params.svh"

module rvExecTb
   import rvExecPkg::*;
();

   localparam int regCount    = 40;
   localparam int immCount    = 40;
   localparam int shiftCount  = 192;   // 32 amounts, 3 shifts, each with a trailer
   localparam int branchCount = 60;
   localparam int luiCount    = 20;
   localparam int burstCount  = 120;
   localparam int directedCount = 1;
   localparam int plannedStrobes = regCount + immCount + shiftCount + branchCount +
                                   luiCount + burstCount + directedCount;
   localparam int cycleLimit = 16 + 24 * plannedStrobes;
   // Decoder, full queue and ALU all holding a long shift
   localparam int drainLimit = 24 * (`RVX_QUEUE_DEPTH + 2);

   logic                 clk;
   logic                 reset;
   logic                 instrValid;
   logic [`RVX_XLEN-1:0] instr;
   logic [`RVX_XLEN-1:0] rs1Data;
   logic [`RVX_XLEN-1:0] rs2Data;
   logic                 busy;
   logic                 resultValid;
   logic [`RVX_XLEN-1:0] result;
   logic                 isBranch;
   logic                 taken;

   logic [31:0]          lcgState = 32'hfac5b8a1;
   logic                 busySeen = 1'b1;   // Busy as of the last negedge
   logic                 busyRaised = 1'b0;
   int                   cycleCount = 0;
   int                   errorCount = 0;
   int                   supportedCount = 0;
   int                   resultsSeen = 0;

   // Expected results in issue order
   string                expLabel[$];
   logic [`RVX_XLEN-1:0] expResult[$];
   logic                 expBranch[$];
   logic                 expTaken[$];

   string                monLabel;
   logic [`RVX_XLEN-1:0] monResult;
   logic                 monBranch;
   logic                 monTaken;

   tbClock u_tbClock (.clk(clk), .reset(reset));

   rvExecTop u_rvExecTop (
      .clk         (clk),
      .reset       (reset),
      .instrValid  (instrValid),
      .instr       (instr),
      .rs1Data     (rs1Data),
      .rs2Data     (rs2Data),
      .busy        (busy),
      .resultValid (resultValid),
      .result      (result),
      .isBranch    (isBranch),
      .taken       (taken)
   );

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
      return lcgState;
   endfunction

   task automatic stopWithFailure();
      $display("Finished with errors");
      $fatal(1, "Simulation stopped on a failed check");
   endtask

   task automatic checkResult(input string testName, input logic [`RVX_XLEN-1:0] expected,
                              input logic [`RVX_XLEN-1:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
         errorCount++;
         stopWithFailure();
      end
   endtask

   task automatic checkFlag(input string testName, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected %b, actual %b", testName, expected, actual);
         errorCount++;
         stopWithFailure();
      end
   endtask

   task automatic checkCount(input string testName, input int expected, input int actual);
      if (actual != expected) begin
         $display("FAILED %s: expected %0d, actual %0d", testName, expected, actual);
         errorCount++;
         stopWithFailure();
      end
   endtask

   // RV32I decode of the kept opcodes, second operand as the spec defines it
   task automatic modelDecode(input logic [31:0] word, input logic [31:0] b, output bit kept,
                              output aluOp_t op, output logic [31:0] operand2);
      logic [2:0] f3;
      f3       = word[14:12];
      kept     = 1'b1;
      op       = ALU_ADD;
      operand2 = b;
      case (word[6:2])
         OP_REG, OP_IMM: begin
            if (word[6:2] == OP_IMM)
               operand2 = {{20{word[31]}}, word[31:20]};   // I-immediate
            case (f3)
               3'b000:  op = (word[6:2] == OP_REG && word[30]) ? ALU_SUB : ALU_ADD;
               3'b001:  op = ALU_SLL;
               3'b010:  op = ALU_SLT;
               3'b011:  op = ALU_SLTU;
               3'b100:  op = ALU_XOR;
               3'b101:  op = word[30] ? ALU_SRA : ALU_SRL;
               3'b110:  op = ALU_OR;
               default: op = ALU_AND;
            endcase
         end
         OP_BRANCH: begin
            case (f3)
               3'b000:  op = ALU_BEQ;
               3'b001:  op = ALU_BNE;
               3'b100:  op = ALU_BLT;
               3'b101:  op = ALU_BGE;
               3'b110:  op = ALU_BLTU;
               default: op = ALU_BGEU;
            endcase
         end
         OP_LUI: begin
            op       = ALU_PASS;
            operand2 = {word[31:12], 12'b0};
         end
         default: kept = 1'b0;   // No result expected
      endcase
   endtask

   task automatic modelExecute(input aluOp_t op, input logic [31:0] a, input logic [31:0] b,
                               output logic [31:0] res, output logic br, output logic tk);
      res = '0;
      br  = 1'b0;
      tk  = 1'b0;
      case (op)
         ALU_ADD:  res = a + b;
         ALU_SUB:  res = a - b;
         ALU_SLL:  res = a << b[4:0];
         ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: res = {31'b0, a < b};
         ALU_XOR:  res = a ^ b;
         ALU_SRL:  res = a >> b[4:0];
         ALU_SRA:  res = $unsigned($signed(a) >>> b[4:0]);
         ALU_OR:   res = a | b;
         ALU_AND:  res = a & b;
         ALU_PASS: res = b;
         default: begin
            br = 1'b1;            // Branch result stays zero
            case (op)
               ALU_BEQ:  tk = (a == b);
               ALU_BNE:  tk = (a != b);
               ALU_BLT:  tk = ($signed(a) < $signed(b));
               ALU_BGE:  tk = ($signed(a) >= $signed(b));
               ALU_BLTU: tk = (a < b);
               default:  tk = (a >= b);
            endcase
         end
      endcase
   endtask

   // Equal, less, greater and opposite-sign pairs
   task automatic pickPair(output logic [31:0] a, output logic [31:0] b);
      logic [31:0] r;
      logic [31:0] s;
      r = nextRand();
      s = nextRand();
      case (r[2:0])
         3'd0:    begin a = s; b = s; end
         3'd1:    begin a = s; b = s + 32'(r[7:4]) + 32'd1; end
         3'd2:    begin a = s; b = s - 32'(r[7:4]) - 32'd1; end
         3'd3:    begin a = {1'b1, s[30:0]}; b = {1'b0, r[30:0]}; end
         3'd4:    begin a = {1'b0, s[30:0]}; b = {1'b1, r[30:0]}; end
         default: begin a = r; b = s; end
      endcase
   endtask

   // Register fields rs2, rs1, rd from high to low
   function automatic logic [31:0] rType(logic [2:0] f3, logic bit30, logic [14:0] regs);
      return {1'b0, bit30, 5'b0, regs[14:5], f3, regs[4:0], 5'(OP_REG), 2'b11};
   endfunction

   function automatic logic [31:0] iType(logic [2:0] f3, logic [11:0] imm, logic [9:0] regs);
      return {imm, regs[9:5], f3, regs[4:0], 5'(OP_IMM), 2'b11};
   endfunction

   // Strobe one word once busy allows it, and record what the model expects
   task automatic issueWord(input string testName, input logic [31:0] word,
                            input logic [31:0] a, input logic [31:0] b);
      bit          kept;
      aluOp_t      op;
      logic [31:0] operand2;
      logic [31:0] res;
      logic        br;
      logic        tk;
      @(posedge clk);
      while (busySeen) @(posedge clk);
      instrValid <= 1'b1;
      instr      <= word;
      rs1Data    <= a;
      rs2Data    <= b;
      modelDecode(word, b, kept, op, operand2);
      if (kept) begin
         modelExecute(op, a, operand2, res, br, tk);
         expLabel.push_back($sformatf("%s %s", testName, op.name()));
         expResult.push_back(res);
         expBranch.push_back(br);
         expTaken.push_back(tk);
         supportedCount++;
      end
      @(posedge clk);
      instrValid <= 1'b0;   // Decoder is one cycle behind busy, so strobes stay apart
   endtask

   task automatic issueRandom(input string testName, input majorOp_t kind);
      logic [31:0] r;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] word;
      logic [2:0]  f3;
      logic [4:0]  opc;
      r  = nextRand();
      f3 = r[14:12];
      pickPair(a, b);
      case (kind)
         OP_REG:  word = rType(f3, (f3 == 3'b000 || f3 == 3'b101) && r[30], r[24:10]);
         OP_IMM: begin
            if (f3 == 3'b001 || f3 == 3'b101)   // Shift immediate keeps funct7 clean
               word = iType(f3, {1'b0, f3[2] & r[30], 5'b0, r[24:20]}, r[19:10]);
            else
               word = iType(f3, r[31:20], r[19:10]);   // Bit 30 here is immediate
         end
         OP_BRANCH: begin
            if (f3[2:1] == 2'b01)
               f3[1] = 1'b0;                // Skip the reserved codes
            word = {r[31:25], r[24:15], f3, r[11:7], 5'(OP_BRANCH), 2'b11};
         end
         OP_LUI:  word = {r[31:12], r[11:7], 5'(OP_LUI), 2'b11};
         default: begin
            opc = r[6:2];
            if (opc == OP_REG || opc == OP_IMM || opc == OP_LUI || opc == OP_BRANCH)
               opc = 5'b00000;              // LOAD
            word = {r[31:7], opc, 2'b11};
         end
      endcase
      issueWord(testName, word, a, b);
   endtask

   function automatic majorOp_t pickKind();
      logic [31:0] pick;
      pick = nextRand() % 32'd5;
      if (pick == 32'd0)
         return OP_REG;
      else if (pick == 32'd1)
         return OP_IMM;
      else if (pick == 32'd2)
         return OP_LUI;
      else if (pick == 32'd3)
         return OP_BRANCH;
      return OP_OTHER;
   endfunction

   // Wait for the outstanding results, bounded so a lost one shows up as a count error
   task automatic drainResults(input string testName);
      int waited;
      waited = 0;
      while (expResult.size() != 0 && waited < drainLimit) begin
         @(posedge clk);
         waited++;
      end
      repeat (4) @(posedge clk);   // Room for a stray extra strobe
      checkCount({testName, " result count"}, supportedCount, resultsSeen);
      checkFlag({testName, " busy when empty"}, 1'b0, busy);
   endtask

   task automatic runTest(input string testName, input majorOp_t kind, input int count,
                          input bit burst);
      for (int i = 0; i < count; i++) begin
         issueRandom(testName, burst ? pickKind() : kind);
         if (!burst)
            repeat (nextRand() % 32'd3) @(posedge clk);
      end
      drainResults(testName);
   endtask

   // Every amount for each shift, a short op queued right behind it
   task automatic runShifts();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] word;
      logic [2:0]  f3;
      for (int amt = 0; amt < 32; amt++) begin
         for (int k = 0; k < 3; k++) begin
            r  = nextRand();
            a  = nextRand();
            f3 = (k == 0) ? 3'b001 : 3'b101;
            if (k == 2 && r[1])
               a[31] = 1'b1;                     // Negative SRA source
            b = {r[31:5], 5'(amt)};             // Only the low five bits count
            if (r[0])
               word = rType(f3, k == 2, r[24:10]);
            else
               word = iType(f3, {1'b0, k == 2, 5'b0, 5'(amt)}, r[19:10]);
            issueWord("shifts", word, a, b);
            issueRandom("shifts", OP_REG);
         end
      end
      drainResults("shifts");
   endtask

   always @(negedge clk) begin
      busySeen <= busy;
      if (busy === 1'b1)
         busyRaised <= 1'b1;   // Queue reached its back-pressure level
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles with %0d results still outstanding",
                  cycleCount, expResult.size());
         stopWithFailure();
      end
   end

   // Results sampled mid cycle
   always @(negedge clk) begin
      if (reset === 1'b1 && resultValid === 1'b1) begin
         if (expResult.size() == 0) begin
            $display("A result strobe came with no instruction outstanding");
            errorCount++;
            stopWithFailure();
         end else begin
            monLabel  = expLabel.pop_front();
            monResult = expResult.pop_front();
            monBranch = expBranch.pop_front();
            monTaken  = expTaken.pop_front();
            checkResult(monLabel, monResult, result);
            checkFlag({monLabel, " isBranch"}, monBranch, isBranch);
            checkFlag({monLabel, " taken"}, monTaken, taken);
            resultsSeen++;
         end
      end
   end

   initial begin
      instrValid = 1'b0;
      instr      = '0;
      rs1Data    = '0;
      rs2Data    = '0;
      while (reset !== 1'b1) @(posedge clk);
      runTest("regOps", OP_REG, regCount, 1'b0);
      runTest("immOps", OP_IMM, immCount, 1'b0);
      // ADDI whose immediate has bit 30 set
      issueWord("addiBit30", iType(3'b000, 12'h4a5, 10'h0c3), 32'h12345678, 32'h0);
      drainResults("addiBit30");
      runShifts();
      runTest("branches", OP_BRANCH, branchCount, 1'b0);
      runTest("lui", OP_LUI, luiCount, 1'b0);
      runTest("burst", OP_OTHER, burstCount, 1'b1);   // Mixed, unsupported words included
      checkFlag("busy raised", 1'b1, busyRaised);
      if (errorCount == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         stopWithFailure();
      end
   end

endmodule

`default_nettype wire

/* rvExec.f */
+incdir+common
common/rvExecPkg.sv
common/aluOpIf.sv
decoder/instrDecoder.sv
rtl/opQueue.sv
alu/aluCore.sv
rtl/rvExecTop.sv
verification/tbClock.sv
verification/rvExecTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rvExecTb
FILELIST = rvExec.f
BUILD    = obj_dir
PASS_MSG = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
